// ==== Bender.yml ====
package:
  name: rrag

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rrag_pkg.sv
      - verilog/tagged_regfile.sv
      - verilog/stage_control.sv
      - verilog/addr_stage.sv
      - verilog/rrag.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/rrag_tb.sv

// ==== bench/rrag_tb.sv ====
`include "rrag_defs.svh"

module rrag_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import rrag_pkg::*;

    typedef struct {
        uop_in_t uop;
        wb_gpr_t wbg;
        wb_seg_t wbs;
        logic    fl;
        logic    cr;
        logic    exp_stall;
        int      test;
    } row_t;

    logic     clk = 1'b0;
    logic     arst_n;
    uop_in_t  in_uop;
    wb_gpr_t  wb_gpr;
    wb_seg_t  wb_seg;
    logic     flush;
    logic     credit_return;
    logic     stall;
    uop_out_t out_uop;

    row_t      rows[$];
    integer    seed = 99;
    tag_t      next_tag = '0;                         // Tag the next issue will get.
    int        cycles = 0;
    int        limit = 0;
    int        errors = 0;
    int        test_err[1:6];

    // Reference state.
    gpr_data_t m_gpr[`RRAG_GPR_N];
    logic      m_gpend[`RRAG_GPR_N];
    tag_t      m_gtag[`RRAG_GPR_N];
    seg_data_t m_seg[`RRAG_SEG_N];
    logic      m_spend[`RRAG_SEG_N];
    tag_t      m_stag[`RRAG_SEG_N];
    int        m_credits;
    tag_t      m_tag;

    rrag dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_uop        (in_uop),
        .wb_gpr        (wb_gpr),
        .wb_seg        (wb_seg),
        .flush         (flush),
        .credit_return (credit_return),
        .stall         (stall),
        .out_uop       (out_uop)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (limit != 0 && cycles >= limit) begin
            $display("Timeout: run did not finish within %0d cycles", limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic uop_in_t mk_uop();
        uop_in_t u;
        u          = '0;
        u.valid    = 1'b1;
        u.sideband = {$random(seed), $random(seed)};
        return u;
    endfunction

    function automatic wb_gpr_t gwb(input int idx, input gpr_data_t d, input tag_t t);
        wb_gpr_t w;
        w.valid = 1'b1;
        w.idx   = idx[2:0];
        w.data  = d;
        w.tag   = t;
        return w;
    endfunction

    function automatic wb_seg_t swb(input int idx, input seg_data_t d, input tag_t t);
        wb_seg_t w;
        w.valid = 1'b1;
        w.idx   = idx[2:0];
        w.data  = d;
        w.tag   = t;
        return w;
    endfunction

    task automatic add_row(input uop_in_t u, input wb_gpr_t g, input wb_seg_t s,
                           input logic fl, input logic cr, input logic st, input int test);
        row_t r;
        r.uop       = u;
        r.wbg       = g;
        r.wbs       = s;
        r.fl        = fl;
        r.cr        = cr;
        r.exp_stall = st;
        r.test      = test;
        rows.push_back(r);
        if (u.valid && !st) next_tag++;
    endtask

    function automatic seg_data_t seg_read(input reg_idx_t idx);
        return (idx < `RRAG_SEG_N) ? m_seg[idx] : '0;
    endfunction

    function automatic logic model_stall(input uop_in_t u);
        logic h1;
        logic h2;
        h1 = u.mem1_use && ((u.use_base && m_gpend[u.gpr_idx[1]]) ||
                            (u.use_index && m_gpend[u.gpr_idx[2]]));
        h2 = (u.mem2_use || u.is_rep) && m_gpend[u.gpr_idx[3]];
        return u.valid && (h1 || h2 || m_credits == 0);
    endfunction

    function automatic uop_out_t predict(input uop_in_t u);
        uop_out_t  p;
        gpr_data_t base;
        gpr_data_t index;
        gpr_data_t bytes;
        p       = '0;
        p.valid = 1'b1;
        p.tag   = m_tag;
        for (int k = 0; k < 4; k++) begin
            p.gpr_data[k] = m_gpr[u.gpr_idx[k]];
            p.gpr_pend[k] = m_gpend[u.gpr_idx[k]];
            p.gpr_tag[k]  = m_gtag[u.gpr_idx[k]];
        end
        p.seg_data[0] = seg_read(u.seg_idx[0]);
        p.seg_data[1] = seg_read(u.seg_idx[1]);
        base  = u.use_base ? p.gpr_data[1] : 32'd0;
        index = u.use_index ? p.gpr_data[2] * (32'd1 << u.scale) : 32'd0;
        case (u.opsize)
            2'd0:    bytes = 32'd1;
            2'd1:    bytes = 32'd2;
            2'd2:    bytes = 32'd4;
            default: bytes = 32'd8;
        endcase
        p.mem_addr1     = base + index + u.disp + {p.seg_data[0], 16'h0000};
        p.mem_addr1_end = p.mem_addr1 + bytes - 32'd1;
        p.mem_addr2     = p.gpr_data[3] + {p.seg_data[1], 16'h0000};
        p.rep_num       = u.is_rep ? p.gpr_data[3] : 32'd0;
        p.opsize        = u.opsize;
        p.sideband      = u.sideband;
        return p;
    endfunction

    task automatic model_edge(input row_t r, input logic iss);
        if (r.wbg.valid) begin
            m_gpr[r.wbg.idx] = r.wbg.data;
            if (r.wbg.tag == m_gtag[r.wbg.idx]) m_gpend[r.wbg.idx] = 1'b0;
        end
        if (r.wbs.valid && r.wbs.idx < `RRAG_SEG_N) begin
            m_seg[r.wbs.idx] = r.wbs.data;
            if (r.wbs.tag == m_stag[r.wbs.idx]) m_spend[r.wbs.idx] = 1'b0;
        end
        if (r.fl) begin
            for (int i = 0; i < `RRAG_GPR_N; i++) m_gpend[i] = 1'b0;
            for (int i = 0; i < `RRAG_SEG_N; i++) m_spend[i] = 1'b0;
        end
        if (iss && r.uop.dst_gpr_valid) begin
            m_gpend[r.uop.dst_gpr_idx] = 1'b1;        // Mark beats the clear.
            m_gtag[r.uop.dst_gpr_idx]  = m_tag;
        end
        if (iss && r.uop.dst_seg_valid && r.uop.dst_seg_idx < `RRAG_SEG_N) begin
            m_spend[r.uop.dst_seg_idx] = 1'b1;
            m_stag[r.uop.dst_seg_idx]  = m_tag;
        end
        m_credits = m_credits - int'(iss) + int'(r.cr);
        if (iss) m_tag++;
    endtask

    task automatic build_table();
        uop_in_t u;
        uop_in_t v;
        tag_t    mt;
        // Test 1, idle then first issue.
        add_row('0, '0, '0, 0, 0, 0, 1);
        add_row(mk_uop(), '0, '0, 0, 1, 0, 1);
        // Test 2, base + scaled index + disp + segment.
        add_row('0, gwb(2, $random(seed), 0), '0, 0, 0, 0, 2);
        add_row('0, gwb(3, $random(seed), 0), swb(1, $random(seed), 0), 0, 0, 0, 2);
        for (int s = 0; s < 4; s++) begin
            u            = mk_uop();
            u.gpr_idx[1] = 3'd2;
            u.gpr_idx[2] = 3'd3;
            u.seg_idx[0] = 3'd1;
            u.use_base   = 1'b1;
            u.use_index  = 1'b1;
            u.mem1_use   = 1'b1;
            u.scale      = s[1:0];
            u.opsize     = s[1:0];
            u.disp       = $random(seed);
            add_row(u, '0, '0, 0, 1, 0, 2);
        end
        // Test 3, base hazard on a pending register.
        mt              = next_tag;
        u               = mk_uop();
        u.dst_gpr_valid = 1'b1;
        u.dst_gpr_idx   = 3'd2;
        add_row(u, '0, '0, 0, 1, 0, 3);
        v            = mk_uop();
        v.gpr_idx[0] = 3'd2;                          // Operand read only.
        add_row(v, '0, '0, 0, 1, 0, 3);
        u            = mk_uop();
        u.gpr_idx[1] = 3'd2;
        u.use_base   = 1'b1;
        u.mem1_use   = 1'b1;
        u.disp       = 32'h0000_1000;
        add_row(u, gwb(2, $random(seed), mt + 1'b1), '0, 0, 0, 1, 3);
        add_row(u, gwb(2, $random(seed), mt), '0, 0, 0, 1, 3);
        add_row(u, '0, '0, 0, 1, 0, 3);
        // Test 4, credits run out.
        u = mk_uop();
        for (int k = 0; k < 4; k++) add_row(u, '0, '0, 0, 0, 0, 4);
        add_row(u, '0, '0, 0, 0, 1, 4);
        add_row(u, '0, '0, 0, 1, 1, 4);
        add_row(u, '0, '0, 0, 0, 0, 4);
        add_row(u, '0, '0, 0, 1, 1, 4);
        add_row(u, '0, '0, 0, 1, 0, 4);               // Return and issue together.
        add_row(u, '0, '0, 0, 0, 0, 4);
        add_row(u, '0, '0, 0, 0, 1, 4);
        for (int k = 0; k < 4; k++) add_row('0, '0, '0, 0, 1, 0, 4);
        // Test 5, rep count waits on register 4.
        u               = mk_uop();
        u.dst_gpr_valid = 1'b1;
        u.dst_gpr_idx   = 3'd4;
        add_row(u, gwb(4, $random(seed), 0), '0, 0, 1, 0, 5);
        u            = mk_uop();
        u.gpr_idx[3] = 3'd4;
        u.seg_idx[1] = 3'd1;
        u.is_rep     = 1'b1;
        u.mem2_use   = 1'b1;
        add_row(u, '0, '0, 0, 0, 1, 5);
        add_row(u, '0, '0, 1, 0, 1, 5);
        add_row(u, '0, '0, 0, 1, 0, 5);
        // Test 6, unused segment slots and segment destinations.
        add_row('0, '0, swb(6, 16'hbeef, 0), 0, 0, 0, 6);
        u            = mk_uop();
        u.seg_idx[0] = 3'd6;
        u.seg_idx[1] = 3'd7;
        add_row(u, '0, '0, 0, 1, 0, 6);
        mt              = next_tag;
        u               = mk_uop();
        u.dst_seg_valid = 1'b1;
        u.dst_seg_idx   = 3'd3;
        add_row(u, '0, '0, 0, 1, 0, 6);
        add_row('0, '0, swb(3, $random(seed), mt + 1'b1), 0, 0, 0, 6);
        add_row('0, '0, swb(3, $random(seed), mt), 0, 0, 0, 6);
        u            = mk_uop();
        u.seg_idx[0] = 3'd3;
        add_row(u, '0, '0, 0, 1, 0, 6);
        add_row('0, '0, '0, 0, 0, 0, 6);
    endtask

    task automatic check_output(input uop_out_t exp, input int test);
        assert (out_uop.valid === exp.valid) else begin
            $display("MISMATCH %0t: out_uop.valid exp %b got %b", $time, exp.valid,
                     out_uop.valid);
            errors++;
            test_err[test]++;
        end
        if (exp.valid) begin
            assert (out_uop === exp) else begin
                $display("MISMATCH %0t: out_uop tag %0d addr1 %h end %h addr2 %h rep %h",
                         $time, out_uop.tag, out_uop.mem_addr1, out_uop.mem_addr1_end,
                         out_uop.mem_addr2, out_uop.rep_num);
                $display("  expected tag %0d addr1 %h end %h addr2 %h rep %h", exp.tag,
                         exp.mem_addr1, exp.mem_addr1_end, exp.mem_addr2, exp.rep_num);
                errors++;
                test_err[test]++;
            end
        end
    endtask

    // Segment pending bits have no path to out_uop.
    task automatic check_seg_pend(input int test);
        for (int i = 0; i < `RRAG_SEG_N; i++) begin
            assert (dut.seg_rf.pend_q[i] === m_spend[i]) else begin
                $display("MISMATCH %0t: segment %0d pending exp %b got %b", $time, i,
                         m_spend[i], dut.seg_rf.pend_q[i]);
                errors++;
                test_err[test]++;
            end
        end
    endtask

    initial begin
        uop_out_t exp_out;
        logic     iss;
        int       cur_test;
        arst_n        = 1'b0;
        in_uop        = '0;
        wb_gpr        = '0;
        wb_seg        = '0;
        flush         = 1'b0;
        credit_return = 1'b0;
        for (int i = 1; i <= 6; i++) test_err[i] = 0;
        for (int i = 0; i < `RRAG_GPR_N; i++) begin
            m_gpr[i]   = '0;
            m_gpend[i] = 1'b0;
            m_gtag[i]  = '0;
        end
        for (int i = 0; i < `RRAG_SEG_N; i++) begin
            m_seg[i]   = '0;
            m_spend[i] = 1'b0;
            m_stag[i]  = '0;
        end
        m_credits = `RRAG_CREDITS;
        m_tag     = '0;
        build_table();
        limit = 4 * rows.size() + 20;
        exp_out  = '0;
        cur_test = rows[0].test;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        foreach (rows[i]) begin
            @(negedge clk);
            check_output(exp_out, cur_test);
            check_seg_pend(cur_test);
            if (rows[i].test != cur_test) begin
                $display("test %0d: %0d errors", cur_test, test_err[cur_test]);
                cur_test = rows[i].test;
            end
            in_uop        = rows[i].uop;
            wb_gpr        = rows[i].wbg;
            wb_seg        = rows[i].wbs;
            flush         = rows[i].fl;
            credit_return = rows[i].cr;
            #1;
            assert (stall === rows[i].exp_stall) else begin
                $display("MISMATCH %0t: row %0d stall exp %b got %b", $time, i,
                         rows[i].exp_stall, stall);
                errors++;
                test_err[cur_test]++;
            end
            iss = rows[i].uop.valid && !model_stall(rows[i].uop);
            exp_out = iss ? predict(rows[i].uop) : uop_out_t'('0);
            @(posedge clk);
            model_edge(rows[i], iss);
        end
        @(negedge clk);
        check_output(exp_out, cur_test);
        check_seg_pend(cur_test);
        $display("test %0d: %0d errors", cur_test, test_err[cur_test]);
        $display("rows %0d, errors %0d", rows.size(), errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+verilog
verilog/rrag_pkg.sv
verilog/tagged_regfile.sv
verilog/stage_control.sv
verilog/addr_stage.sv
verilog/rrag.sv
bench/rrag_tb.sv

// ==== verilog/addr_stage.sv ====
`include "rrag_defs.svh"

module addr_stage (
    input  logic                      clk,
    input  logic                      arst_n,

    input  logic                      issue,
    input  rrag_pkg::tag_t            issue_tag,
    input  rrag_pkg::uop_in_t         in_uop,

    input  rrag_pkg::gpr_data_t [3:0] gpr_data,
    input  logic [3:0]                gpr_pend,
    input  rrag_pkg::tag_t [3:0]      gpr_tag,
    input  rrag_pkg::seg_data_t [1:0] seg_data,

    output rrag_pkg::uop_out_t        out_uop
);

    import rrag_pkg::*;

    gpr_data_t base_val;
    gpr_data_t index_val;
    gpr_data_t seg1_shf;
    gpr_data_t seg2_shf;
    gpr_data_t size_m1;
    gpr_data_t addr1;
    gpr_data_t addr1_end;
    gpr_data_t addr2;
    gpr_data_t rep_val;

    assign base_val  = in_uop.use_base  ? gpr_data[1] : '0;
    assign index_val = in_uop.use_index ? (gpr_data[2] << in_uop.scale) : '0;

    assign seg1_shf  = {seg_data[0], 16'h0000};
    assign seg2_shf  = {seg_data[1], 16'h0000};

    // Wraps at 2**32.
    assign addr1     = base_val + index_val + in_uop.disp + seg1_shf;

    assign size_m1   = (32'd1 << in_uop.opsize) - 32'd1;
    assign addr1_end = addr1 + size_m1;               // Last byte touched.

    assign addr2     = gpr_data[3] + seg2_shf;
    assign rep_val   = in_uop.is_rep ? gpr_data[3] : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_uop <= '0;
        end else begin
            out_uop.valid <= issue;                   // One cycle per issue.
            if (issue) begin
                out_uop.tag           <= issue_tag;
                out_uop.gpr_data      <= gpr_data;
                out_uop.gpr_pend      <= gpr_pend;
                out_uop.gpr_tag       <= gpr_tag;
                out_uop.seg_data      <= seg_data;
                out_uop.mem_addr1     <= addr1;
                out_uop.mem_addr1_end <= addr1_end;
                out_uop.mem_addr2     <= addr2;
                out_uop.rep_num       <= rep_val;
                out_uop.opsize        <= in_uop.opsize;
                out_uop.sideband      <= in_uop.sideband;
            end
        end
    end

endmodule

// ==== verilog/rrag.sv ====
`include "rrag_defs.svh"

module rrag (
    input  logic               clk,
    input  logic               arst_n,

    input  rrag_pkg::uop_in_t  in_uop,
    input  rrag_pkg::wb_gpr_t  wb_gpr,
    input  rrag_pkg::wb_seg_t  wb_seg,

    input  logic               flush,
    input  logic               credit_return,

    output logic               stall,
    output rrag_pkg::uop_out_t out_uop
);

    import rrag_pkg::*;

    logic            issue;
    tag_t            issue_tag;

    gpr_data_t [3:0] gpr_data;
    logic [3:0]      gpr_pend;
    tag_t [3:0]      gpr_tag;
    seg_data_t [1:0] seg_data;

    tagged_regfile #(
        .entry_t    (gpr_data_t),
        .ENTRIES    (`RRAG_GPR_N),
        .READ_PORTS (4)
    ) gpr_rf (
        .clk      (clk),
        .arst_n   (arst_n),
        .rd_idx   (in_uop.gpr_idx),
        .rd_data  (gpr_data),
        .rd_pend  (gpr_pend),
        .rd_tag   (gpr_tag),
        .wb_valid (wb_gpr.valid),
        .wb_idx   (wb_gpr.idx),
        .wb_data  (wb_gpr.data),
        .wb_tag   (wb_gpr.tag),
        .mark     (issue && in_uop.dst_gpr_valid),
        .mark_idx (in_uop.dst_gpr_idx),
        .mark_tag (issue_tag),
        .flush    (flush)
    );

    // Segment pending state only matters to later consumers.
    tagged_regfile #(
        .entry_t    (seg_data_t),
        .ENTRIES    (`RRAG_SEG_N),
        .READ_PORTS (2)
    ) seg_rf (
        .clk      (clk),
        .arst_n   (arst_n),
        .rd_idx   (in_uop.seg_idx),
        .rd_data  (seg_data),
        .rd_pend  (),
        .rd_tag   (),
        .wb_valid (wb_seg.valid),
        .wb_idx   (wb_seg.idx),
        .wb_data  (wb_seg.data),
        .wb_tag   (wb_seg.tag),
        .mark     (issue && in_uop.dst_seg_valid),
        .mark_idx (in_uop.dst_seg_idx),
        .mark_tag (issue_tag),
        .flush    (flush)
    );

    stage_control u_stage_control (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_uop        (in_uop),
        .gpr_pend      (gpr_pend),
        .credit_return (credit_return),
        .stall         (stall),
        .issue         (issue),
        .issue_tag     (issue_tag)
    );

    addr_stage u_addr_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .issue     (issue),
        .issue_tag (issue_tag),
        .in_uop    (in_uop),
        .gpr_data  (gpr_data),
        .gpr_pend  (gpr_pend),
        .gpr_tag   (gpr_tag),
        .seg_data  (seg_data),
        .out_uop   (out_uop)
    );

endmodule

// ==== verilog/rrag_defs.svh ====
`ifndef RRAG_DEFS_SVH
`define RRAG_DEFS_SVH

// Micro-op tag width, tags wrap after 2**W issues.
`define RRAG_TAG_W 4

// General register count.
`define RRAG_GPR_N 8

// Segment register count, higher indices read as zero.
`define RRAG_SEG_N 6

// Downstream slots granted after reset.
`define RRAG_CREDITS 4

// Opaque decode fields carried to the next stage.
`define RRAG_SIDEBAND_W 64

// Widths of the data paths.
`define RRAG_GPR_W 32
`define RRAG_SEG_W 16
`define RRAG_IDX_W 3

`endif

// ==== verilog/rrag_pkg.sv ====
`include "rrag_defs.svh"

package rrag_pkg;

    typedef logic [`RRAG_TAG_W-1:0]      tag_t;
    typedef logic [`RRAG_IDX_W-1:0]      reg_idx_t;
    typedef logic [`RRAG_GPR_W-1:0]      gpr_data_t;
    typedef logic [`RRAG_SEG_W-1:0]      seg_data_t;
    typedef logic [`RRAG_SIDEBAND_W-1:0] sideband_t;

    // Read port 0 is reg1, port 1 the base, port 2 the index, port 3 the string pointer.
    typedef struct packed {
        logic                valid;
        reg_idx_t [3:0]      gpr_idx;
        reg_idx_t [1:0]      seg_idx;
        logic                use_base;
        logic                use_index;
        logic [1:0]          scale;      // Index shift, 0 to 3.
        gpr_data_t           disp;
        logic [1:0]          opsize;     // 1, 2, 4 or 8 bytes.
        logic                mem1_use;
        logic                mem2_use;
        logic                is_rep;
        logic                dst_gpr_valid;
        reg_idx_t            dst_gpr_idx;
        logic                dst_seg_valid;
        reg_idx_t            dst_seg_idx;
        sideband_t           sideband;
    } uop_in_t;

    typedef struct packed {
        logic      valid;
        reg_idx_t  idx;
        gpr_data_t data;
        tag_t      tag;
    } wb_gpr_t;

    typedef struct packed {
        logic      valid;
        reg_idx_t  idx;
        seg_data_t data;
        tag_t      tag;
    } wb_seg_t;

    typedef struct packed {
        logic                valid;
        tag_t                tag;
        gpr_data_t [3:0]     gpr_data;
        logic [3:0]          gpr_pend;   // Still in flight, forward by tag.
        tag_t [3:0]          gpr_tag;
        seg_data_t [1:0]     seg_data;
        gpr_data_t           mem_addr1;
        gpr_data_t           mem_addr1_end;
        gpr_data_t           mem_addr2;
        gpr_data_t           rep_num;
        logic [1:0]          opsize;
        sideband_t           sideband;
    } uop_out_t;

endpackage

// ==== verilog/stage_control.sv ====
`include "rrag_defs.svh"

module stage_control (
    input  logic              clk,
    input  logic              arst_n,

    input  rrag_pkg::uop_in_t in_uop,
    input  logic [3:0]        gpr_pend,
    input  logic              credit_return,

    output logic              stall,
    output logic              issue,
    output rrag_pkg::tag_t    issue_tag
);

    import rrag_pkg::*;

    localparam int CRED_W = $clog2(`RRAG_CREDITS + 1);

    logic [CRED_W-1:0] credits_q;
    tag_t              tag_q;

    logic base_hazard;
    logic index_hazard;
    logic mem1_hazard;
    logic mem2_hazard;
    logic no_credit;

    assign base_hazard  = in_uop.use_base  && gpr_pend[1];
    assign index_hazard = in_uop.use_index && gpr_pend[2];
    assign mem1_hazard  = in_uop.mem1_use && (base_hazard || index_hazard);

    // String ops and rep count both read the pointer register.
    assign mem2_hazard  = (in_uop.mem2_use || in_uop.is_rep) && gpr_pend[3];

    assign no_credit    = (credits_q == '0);

    assign stall = in_uop.valid && (mem1_hazard || mem2_hazard || no_credit);
    assign issue = in_uop.valid && !stall;

    assign issue_tag = tag_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credits_q <= CRED_W'(`RRAG_CREDITS);
        end else begin
            case ({issue, credit_return})
                2'b10:   credits_q <= credits_q - 1'b1;   // Slot taken.
                2'b01:   credits_q <= credits_q + 1'b1;   // Slot freed.
                default: credits_q <= credits_q;
            endcase
        end
    end

    // Tags wrap freely.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tag_q <= '0;
        end else if (issue) begin
            tag_q <= tag_q + 1'b1;
        end
    end

endmodule

// ==== verilog/tagged_regfile.sv ====
`include "rrag_defs.svh"

module tagged_regfile #(
    parameter type entry_t    = rrag_pkg::gpr_data_t,
    parameter int  ENTRIES    = `RRAG_GPR_N,
    parameter int  READ_PORTS = 4
) (
    input  logic                                clk,
    input  logic                                arst_n,

    input  rrag_pkg::reg_idx_t [READ_PORTS-1:0] rd_idx,
    output entry_t [READ_PORTS-1:0]             rd_data,
    output logic [READ_PORTS-1:0]               rd_pend,
    output rrag_pkg::tag_t [READ_PORTS-1:0]     rd_tag,

    input  logic                                wb_valid,
    input  rrag_pkg::reg_idx_t                  wb_idx,
    input  entry_t                              wb_data,
    input  rrag_pkg::tag_t                      wb_tag,

    input  logic                                mark,
    input  rrag_pkg::reg_idx_t                  mark_idx,
    input  rrag_pkg::tag_t                      mark_tag,

    input  logic                                flush
);

    import rrag_pkg::*;

    entry_t             data_q [ENTRIES];
    logic [ENTRIES-1:0] pend_q;
    tag_t               tag_q  [ENTRIES];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pend_q <= '0;
            for (int i = 0; i < ENTRIES; i++) begin
                data_q[i] <= '0;
                tag_q[i]  <= '0;
            end
        end else begin
            for (int i = 0; i < ENTRIES; i++) begin
                if (wb_valid && wb_idx == i) begin
                    data_q[i] <= wb_data;
                    // A stale tag means a younger writer is still in flight.
                    if (wb_tag == tag_q[i]) begin
                        pend_q[i] <= 1'b0;
                    end
                end

                if (flush) begin
                    pend_q[i] <= 1'b0;                // Data is kept.
                end

                if (mark && mark_idx == i) begin
                    pend_q[i] <= 1'b1;                // Overrides clear.
                    tag_q[i]  <= mark_tag;
                end
            end
        end
    end

    // Reads see stored state only, no bypass from writeback.
    always_comb begin
        for (int p = 0; p < READ_PORTS; p++) begin
            if (rd_idx[p] < ENTRIES) begin
                rd_data[p] = data_q[rd_idx[p]];
                rd_pend[p] = pend_q[rd_idx[p]];
                rd_tag[p]  = tag_q[rd_idx[p]];
            end else begin
                rd_data[p] = '0;                      // Unused index.
                rd_pend[p] = 1'b0;
                rd_tag[p]  = '0;
            end
        end
    end

endmodule
